// ==== des_macros.svh ====
`ifndef DES_MACROS_SVH
`define DES_MACROS_SVH

// data block width
`define DES_BLOCK_W 64

// key width, parity bits included
`define DES_KEY_W 64

`define DES_ROUNDS 16

`define DES_SUBKEY_W 48

`endif

// ==== desPkg.sv ====
`include "des_macros.svh"

package desPkg;

    typedef enum logic [1:0] {
        OpNone    = 2'd0,
        OpEncrypt = 2'd1,
        OpDecrypt = 2'd2
    } desOpcode_e;

    typedef enum logic {
        StIdle = 1'b0,
        StRun  = 1'b1
    } desState_e;

    typedef struct packed {
        desOpcode_e              opcode;
        logic [`DES_KEY_W-1:0]   key;
        logic [`DES_BLOCK_W-1:0] block;
    } desCmd_t;

    typedef struct packed {
        logic       load;
        logic       step;
        logic       finish;
        logic       decrypt;
        logic [3:0] roundIdx;
    } desCtrl_t;

    // bit numbers count from 1 at the msb, as in the standard
    localparam bit [6:0] IP [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam bit [6:0] FP [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25
    };

    localparam bit [6:0] E [48] = '{
        32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11,
        12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
        22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
    };

    localparam bit [6:0] P [32] = '{
        16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
        2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
    };

    localparam bit [6:0] PC1 [56] = '{
        57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
        10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
        14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
    };

    localparam bit [6:0] PC2 [48] = '{
        14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10,
        23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    localparam bit [1:0] SHIFTS [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    // row-major, four rows of sixteen columns per box
    localparam bit [3:0] SBOX [8][64] = '{
        '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
          0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
          4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
          15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
        '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
          3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
          0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
          13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
        '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
          13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
          13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
          1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
        '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
          13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
          10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
          3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
        '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
          14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
          4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
          11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
        '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
          10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
          9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
          4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
        '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
          13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
          1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
          6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
        '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
          1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
          7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
          2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
    };

endpackage

// ==== desSbox.sv ====
`timescale 1ns/1ps

module desSbox
    import desPkg::*;
#(
    parameter int BoxIndex = 0
)
(
    input  logic [5:0] bin,
    output logic [3:0] sout
);

    logic [5:0] offset;

    // row from the outer bits, column from the middle four
    assign offset = {bin[5], bin[0], bin[4:1]};
    assign sout = SBOX[BoxIndex][offset];

endmodule

// ==== desCmdDecode.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module desCmdDecode
    import desPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  desOpcode_e opcode,
    output desCtrl_t   ctrl,
    output logic       busy
);

    desState_e  state;
    logic [3:0] roundQ;
    logic       decryptQ;
    logic       tailQ;
    logic       accept;
    logic       lastRound;

    assign accept = start && !busy && (opcode != OpNone);
    assign lastRound = (state == StRun) && (roundQ == 4'(`DES_ROUNDS - 1));

    // tailQ covers the cycle in which the result stage captures
    assign busy = (state == StRun) || tailQ;

    always_comb
    begin
        ctrl.load     = accept;
        ctrl.step     = (state == StRun);
        ctrl.finish   = lastRound;
        ctrl.decrypt  = accept ? (opcode == OpDecrypt) : decryptQ;
        ctrl.roundIdx = roundQ;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= StIdle;
            roundQ   <= '0;
            decryptQ <= 1'b0;
            tailQ    <= 1'b0;
        end
        else
        begin
            tailQ <= lastRound;
            case (state)
                StIdle:
                begin
                    if (accept)
                    begin
                        state    <= StRun;
                        roundQ   <= '0;
                        decryptQ <= (opcode == OpDecrypt);
                    end
                end
                StRun:
                begin
                    roundQ <= roundQ + 4'd1;
                    if (lastRound)
                    begin
                        state <= StIdle;
                    end
                end
                default:
                begin
                    state <= StIdle;
                end
            endcase
        end
    end

endmodule

// ==== desKeySchedule.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module desKeySchedule
    import desPkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  desCtrl_t                 ctrl,
    input  logic [`DES_KEY_W-1:0]    key,
    output logic [`DES_SUBKEY_W-1:0] subKey
);

    logic [55:0] pc1Out;
    logic [27:0] cQ;
    logic [27:0] dQ;
    logic [55:0] cd;
    logic [3:0]  shiftIdx;
    logic [1:0]  shiftAmt;

    // rotate one 28-bit half by one or two places
    function automatic logic [27:0] rotate(input logic [27:0] v, input logic [1:0] n,
                                           input logic right);
        logic [27:0] r;
        if (right)
        begin
            r = (n == 2'd2) ? {v[1:0], v[27:2]} : {v[0], v[27:1]};
        end
        else
        begin
            r = (n == 2'd2) ? {v[25:0], v[27:26]} : {v[26:0], v[27]};
        end
        return r;
    endfunction

    // PC-1 drops the parity bits
    always_comb
    begin
        for (int i = 0; i < 56; i++)
        begin
            pc1Out[55 - i] = key[`DES_KEY_W - PC1[i]];
        end
    end

    // encryption rotates ahead for the next round, decryption walks back
    assign shiftIdx = ctrl.decrypt ? (4'd15 - ctrl.roundIdx) : (ctrl.roundIdx + 4'd1);
    assign shiftAmt = SHIFTS[shiftIdx];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cQ <= '0;
            dQ <= '0;
        end
        else if (ctrl.load)
        begin
            // unrotated halves are C16 and D16, the first decryption key
            cQ <= ctrl.decrypt ? pc1Out[55:28] : rotate(pc1Out[55:28], SHIFTS[0], 1'b0);
            dQ <= ctrl.decrypt ? pc1Out[27:0] : rotate(pc1Out[27:0], SHIFTS[0], 1'b0);
        end
        else if (ctrl.step)
        begin
            cQ <= rotate(cQ, shiftAmt, ctrl.decrypt);
            dQ <= rotate(dQ, shiftAmt, ctrl.decrypt);
        end
    end

    assign cd = {cQ, dQ};

    always_comb
    begin
        for (int i = 0; i < `DES_SUBKEY_W; i++)
        begin
            subKey[`DES_SUBKEY_W - 1 - i] = cd[56 - PC2[i]];
        end
    end

endmodule

// ==== desRound.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module desRound
    import desPkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  desCtrl_t                 ctrl,
    input  logic [`DES_BLOCK_W-1:0]  block,
    input  logic [`DES_SUBKEY_W-1:0] subKey,
    output logic [`DES_BLOCK_W-1:0]  preOutput
);

    logic [`DES_BLOCK_W-1:0]  ipOut;
    logic [31:0]              lQ;
    logic [31:0]              rQ;
    logic [`DES_SUBKEY_W-1:0] expanded;
    logic [`DES_SUBKEY_W-1:0] mixed;
    logic [31:0]              sOut;
    logic [31:0]              fOut;

    always_comb
    begin
        for (int i = 0; i < `DES_BLOCK_W; i++)
        begin
            ipOut[`DES_BLOCK_W - 1 - i] = block[`DES_BLOCK_W - IP[i]];
        end
    end

    // f function, expansion and key mix
    always_comb
    begin
        for (int i = 0; i < `DES_SUBKEY_W; i++)
        begin
            expanded[`DES_SUBKEY_W - 1 - i] = rQ[32 - E[i]];
        end
    end

    assign mixed = expanded ^ subKey;

    // box 0 takes the leftmost six bits
    for (genvar g = 0; g < 8; g++)
    begin : gSbox
        desSbox #(
            .BoxIndex(g)
        ) sbox (
            .bin  (mixed[47 - 6 * g -: 6]),
            .sout (sOut[31 - 4 * g -: 4])
        );
    end

    always_comb
    begin
        for (int i = 0; i < 32; i++)
        begin
            fOut[31 - i] = sOut[32 - P[i]];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lQ <= '0;
            rQ <= '0;
        end
        else if (ctrl.load)
        begin
            {lQ, rQ} <= ipOut;
        end
        else if (ctrl.step)
        begin
            lQ <= rQ;
            rQ <= lQ ^ fOut;
        end
    end

    assign preOutput = {lQ, rQ};

endmodule

// ==== desResult.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module desResult
    import desPkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  desCtrl_t                ctrl,
    input  logic [`DES_BLOCK_W-1:0] preOutput,
    output logic [`DES_BLOCK_W-1:0] dataOut,
    output logic                    done
);

    logic                    finishQ;
    logic [`DES_BLOCK_W-1:0] swapped;
    logic [`DES_BLOCK_W-1:0] fpOut;

    // output is R16 then L16
    assign swapped = {preOutput[31:0], preOutput[63:32]};

    always_comb
    begin
        for (int i = 0; i < `DES_BLOCK_W; i++)
        begin
            fpOut[`DES_BLOCK_W - 1 - i] = swapped[`DES_BLOCK_W - FP[i]];
        end
    end

    // round 16 lands on the finish edge, captured one edge later
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            finishQ <= 1'b0;
            done    <= 1'b0;
            dataOut <= '0;
        end
        else
        begin
            finishQ <= ctrl.finish;
            done    <= finishQ;
            if (finishQ)
            begin
                dataOut <= fpOut;
            end
        end
    end

endmodule

// ==== desCore.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module desCore
    import desPkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  desCmd_t                 cmd,
    output logic                    busy,
    output logic                    done,
    output logic [`DES_BLOCK_W-1:0] dataOut
);

    desCtrl_t                 ctrl;
    logic [`DES_SUBKEY_W-1:0] subKey;
    logic [`DES_BLOCK_W-1:0]  preOutput;

    desCmdDecode cmdDecode (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .opcode (cmd.opcode),
        .ctrl   (ctrl),
        .busy   (busy)
    );

    desKeySchedule keySchedule (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl),
        .key    (cmd.key),
        .subKey (subKey)
    );

    desRound round (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .block     (cmd.block),
        .subKey    (subKey),
        .preOutput (preOutput)
    );

    desResult result (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .preOutput (preOutput),
        .dataOut   (dataOut),
        .done      (done)
    );

endmodule

// ==== desCore_props.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module desCoreProps
    import desPkg::*;
(
    input logic    clk,
    input logic    reset,
    input logic    start,
    input desCmd_t cmd,
    input logic    busy,
    input logic    done
);

    logic accepted;

    assign accepted = start && !busy && (cmd.opcode != OpNone);

    doneSinglePulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for a second cycle");

    // done rises on the 17th edge, so it is sampled one edge after that
    doneLatency: assert property (@(posedge clk) disable iff (reset)
        accepted |-> ##(`DES_ROUNDS + 2) done)
        else $error("done missing 17 edges after an accepted start");

    busyFallsWithDone: assert property (@(posedge clk) disable iff (reset)
        $rose(done) |-> !busy && $past(busy))
        else $error("busy did not fall together with done");

endmodule

// ==== desCoreTb.sv ====
`timescale 1ns/1ps
`include "des_macros.svh"

module desCoreTb
    import desPkg::*;
();

    typedef struct packed {
        desOpcode_e              opcode;
        logic [`DES_KEY_W-1:0]   key;
        logic [`DES_BLOCK_W-1:0] dataIn;
        logic [`DES_BLOCK_W-1:0] expected;
        logic                    disturb;
    } vector_t;

    localparam int NumVectors = 6;
    localparam int NumRandom = 8;
    localparam int ClkPeriod = 20;
    localparam int DoneLatency = `DES_ROUNDS + 1;
    localparam int WatchdogNs = (NumVectors + 2 * NumRandom + 2) * 20 * ClkPeriod;

    logic                    clk;
    logic                    reset;
    logic                    start;
    desCmd_t                 cmd;
    logic                    busy;
    logic                    done;
    logic [`DES_BLOCK_W-1:0] dataOut;

    vector_t vectors [NumVectors];
    integer  seed;
    int      testsRun;
    int      testsFailed;

    desCore UUT (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .cmd     (cmd),
        .busy    (busy),
        .done    (done),
        .dataOut (dataOut)
    );

    bind desCore desCoreProps props (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .cmd   (cmd),
        .busy  (busy),
        .done  (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial
    begin
        #(WatchdogNs);
        $display("Timeout: the run did not finish within %0d ns", WatchdogNs);
        $display("Some tests failed");
        $finish;
    end

    task automatic recordTest(input string name, input logic ok);
        testsRun++;
        if (!ok)
        begin
            testsFailed++;
        end
        $display("test %0d %s: %s", testsRun, name, ok ? "PASS" : "FAIL");
    endtask

    // called 2 ns after an edge, returns 2 ns after the done edge
    task automatic runOp(input desOpcode_e op, input logic [63:0] key,
                         input logic [63:0] dataIn, input logic disturb,
                         output logic [63:0] result, output logic ok);
        int edges;
        ok = 1'b1;
        edges = 0;
        start = 1'b1;
        cmd.opcode = op;
        cmd.key = key;
        cmd.block = dataIn;
        @(posedge clk);
        #2;
        assert (busy === 1'b1)
        else
        begin
            $display("busy did not rise on the start edge");
            ok = 1'b0;
        end
        while (done !== 1'b1 && edges < DoneLatency + 4)
        begin
            if (disturb && edges == 5)
            begin
                // second command while busy must be ignored
                start = 1'b1;
                cmd.opcode = OpEncrypt;
                cmd.key = ~key;
                cmd.block = ~dataIn;
            end
            else
            begin
                start = 1'b0;
                cmd = '0;
            end
            @(posedge clk);
            #2;
            edges++;
            if (done !== 1'b1)
            begin
                assert (busy === 1'b1)
                else
                begin
                    $display("busy dropped before done, %0d edges after start", edges);
                    ok = 1'b0;
                end
            end
        end
        assert (done === 1'b1)
        else
        begin
            $display("done never rose within %0d edges of the start edge", edges);
            ok = 1'b0;
        end
        assert (edges == DoneLatency)
        else
        begin
            $display("done rose %0d edges after the start edge instead of %0d",
                     edges, DoneLatency);
            ok = 1'b0;
        end
        assert (busy === 1'b0)
        else
        begin
            $display("** Error: busy = %h, expected %h", busy, 1'b0);
            ok = 1'b0;
        end
        result = dataOut;
    endtask

    task automatic checkReset();
        logic ok;
        ok = 1'b1;
        assert (busy === 1'b0 && done === 1'b0)
        else
        begin
            $display("** Error: busy = %h, done = %h, expected %h", busy, done, 1'b0);
            ok = 1'b0;
        end
        assert (dataOut === '0)
        else
        begin
            $display("** Error: dataOut = %h, expected %h", dataOut, 64'h0);
            ok = 1'b0;
        end
        recordTest("reset state", ok);
    endtask

    task automatic runVectors();
        logic [63:0] result;
        logic        ok;
        for (int i = 0; i < NumVectors; i++)
        begin
            runOp(vectors[i].opcode, vectors[i].key, vectors[i].dataIn,
                  vectors[i].disturb, result, ok);
            assert (result === vectors[i].expected)
            else
            begin
                $display("** Error: dataOut = %h, expected %h", result, vectors[i].expected);
                ok = 1'b0;
            end
            recordTest($sformatf("vector %0d %s", i, vectors[i].opcode.name()), ok);
        end
    endtask

    task automatic checkOpNone();
        logic        ok;
        logic [63:0] held;
        ok = 1'b1;
        // last table result stays on the output
        held = vectors[NumVectors - 1].expected;
        start = 1'b1;
        cmd.opcode = OpNone;
        cmd.key = {$random(seed), $random(seed)};
        cmd.block = {$random(seed), $random(seed)};
        @(posedge clk);
        #2;
        start = 1'b0;
        cmd = '0;
        repeat (20)
        begin
            @(posedge clk);
            #2;
            assert (done === 1'b0 && busy === 1'b0)
            else
            begin
                $display("a start with OpNone was accepted");
                ok = 1'b0;
            end
        end
        assert (dataOut === held)
        else
        begin
            $display("** Error: dataOut = %h, expected %h", dataOut, held);
            ok = 1'b0;
        end
        recordTest("ignored OpNone start", ok);
    endtask

    task automatic runRoundTrips();
        logic [63:0] key;
        logic [63:0] plain;
        logic [63:0] cipher;
        logic [63:0] back;
        logic        okEnc;
        logic        okDec;
        for (int t = 0; t < NumRandom; t++)
        begin
            key = {$random(seed), $random(seed)};
            plain = {$random(seed), $random(seed)};
            runOp(OpEncrypt, key, plain, 1'b0, cipher, okEnc);
            runOp(OpDecrypt, key, cipher, 1'b0, back, okDec);
            assert (back === plain)
            else
            begin
                $display("** Error: dataOut = %h, expected %h", back, plain);
                okDec = 1'b0;
            end
            recordTest($sformatf("round trip %0d key %h", t, key), okEnc && okDec);
        end
    endtask

    initial
    begin
        // published DES known answers, then the same pairs run backwards
        vectors[0] = '{OpEncrypt, 64'h133457799BBCDFF1, 64'h0123456789ABCDEF,
                       64'h85E813540F0AB405, 1'b0};
        vectors[1] = '{OpEncrypt, 64'h0E329232EA6D0D73, 64'h8787878787878787,
                       64'h0000000000000000, 1'b0};
        vectors[2] = '{OpEncrypt, 64'h0000000000000000, 64'h0000000000000000,
                       64'h8CA64DE9C1B123A7, 1'b0};
        vectors[3] = '{OpDecrypt, 64'h133457799BBCDFF1, 64'h85E813540F0AB405,
                       64'h0123456789ABCDEF, 1'b0};
        vectors[4] = '{OpDecrypt, 64'h0E329232EA6D0D73, 64'h0000000000000000,
                       64'h8787878787878787, 1'b1};
        vectors[5] = '{OpDecrypt, 64'h0000000000000000, 64'h8CA64DE9C1B123A7,
                       64'h0000000000000000, 1'b0};
        seed = 32'h38d89817;
        testsRun = 0;
        testsFailed = 0;
        reset = 1'b1;
        start = 1'b0;
        cmd = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        checkReset();
        runVectors();
        checkOpNone();
        runRoundTrips();
        $display("%0d tests run, %0d passed, %0d failed",
                 testsRun, testsRun - testsFailed, testsFailed);
        if (testsFailed == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
desPkg.sv
desSbox.sv
desCmdDecode.sv
desKeySchedule.sv
desRound.sv
desResult.sv
desCore.sv
desCore_props.sv
desCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= desCoreTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | awk '{ print } /All tests passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)
